// ==== src/i2c_bus_pkg.sv ====
package i2c_bus_pkg;

    // ******************************
    // widths with a meaning
    // ******************************
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_addr_t;
    typedef logic [6:0]  dev_addr_t;

    // ******************************
    // host side command and result
    // ******************************
    typedef struct packed {
        logic       rh_wl;     // 1 = read
        logic       bit_ctrl;  // 1 = 16-bit word address
        word_addr_t addr;
        byte_t      data_w;
    } i2c_cmd_t;

    typedef struct packed {
        logic  xfer_end;       // stop finished
        logic  rd_valid;
        byte_t rd_byte;
    } i2c_result_t;

endpackage

// ==== src/i2c_seq_pkg.sv ====
package i2c_seq_pkg;

    import i2c_bus_pkg::*;

    // transaction states, one per byte on the wire
    typedef enum logic [2:0] {
        st_idle,
        st_sladdr,
        st_addr16,
        st_addr8,
        st_data_wr,
        st_addr_rd,
        st_data_rd,
        st_stop
    } seq_state_t;

    typedef enum logic [2:0] {
        ph_start_byte,     // start + byte + ack
        ph_byte,           // byte + ack
        ph_restart_byte,   // repeated start + byte + ack
        ph_read_byte,      // byte in + nack
        ph_stop
    } phase_kind_t;

    typedef struct packed {
        logic        go;
        phase_kind_t kind;
        byte_t       tx;
    } phase_req_t;

    localparam int TICKS_PER_BIT   = 4;
    localparam int STOP_IDLE_TICKS = 12;

endpackage

// ==== src/i2c_quarter_tick.sv ====
`timescale 1ns/100ps

module i2c_quarter_tick #(
    parameter int CLK_FREQ = 50_000_000,
    parameter int I2C_FREQ = 250_000
) (
    input  logic dri_clk,
    input  logic rst_n,
    output logic tick
);

    localparam int DIV_RAW = CLK_FREQ / (4 * I2C_FREQ);
    localparam int DIV     = (DIV_RAW > 1) ? DIV_RAW : 1;
    localparam int CNT_W   = (DIV > 1) ? $clog2(DIV) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(DIV - 1);

    logic [CNT_W-1:0] div_cnt;

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (div_cnt == LAST) begin
            div_cnt <= '0;
            tick    <= 1'b1;   // four per scl period
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

    a_tick_single : assert property (@(posedge dri_clk) disable iff (!rst_n)
        tick |=> (DIV == 1) || !tick)
    else $error("quarter tick high on two cycles in a row");

endmodule

// ==== src/i2c_cmd_capture.sv ====
`timescale 1ns/100ps

module i2c_cmd_capture import i2c_bus_pkg::*; (
    input  logic       dri_clk,
    input  logic       rst_n,
    input  logic       i2c_exec,
    input  logic       i2c_rh_wl,
    input  logic       bit_ctrl,
    input  word_addr_t i2c_addr,
    input  byte_t      i2c_data_w,
    input  logic       idle,
    output i2c_cmd_t   cmd,
    output logic       cmd_start
);

    logic accept;

    // sequencer still reads idle during the cmd_start cycle
    assign accept = i2c_exec && idle && !cmd_start;

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n)
            cmd_start <= 1'b0;
        else
            cmd_start <= accept;
    end

    always_ff @(posedge dri_clk) begin
        if (accept)
            cmd <= '{rh_wl: i2c_rh_wl, bit_ctrl: bit_ctrl,
                     addr: i2c_addr, data_w: i2c_data_w};
    end

endmodule

// ==== src/i2c_sequencer.sv ====
`timescale 1ns/100ps

module i2c_sequencer import i2c_bus_pkg::*, i2c_seq_pkg::*; #(
    parameter dev_addr_t SLAVE_ADDR = 7'b1010000
) (
    input  logic        dri_clk,
    input  logic        rst_n,
    input  i2c_cmd_t    cmd,
    input  logic        cmd_start,
    input  logic        phase_done,
    input  byte_t       rx_byte,
    output logic        idle,
    output phase_req_t  req,
    output i2c_result_t result
);

    seq_state_t state;
    seq_state_t nxt_state;
    logic       xfer_end;
    logic       rd_valid;
    byte_t      rd_byte;

    // phase kind and transmit byte for the byte a state puts on the wire
    function automatic phase_req_t phase_for(seq_state_t st, i2c_cmd_t c);
        phase_req_t p;
        p.go   = (st != st_idle);
        p.kind = ph_byte;
        p.tx   = c.data_w;
        case (st)
            st_sladdr: begin
                p.kind = ph_start_byte;
                p.tx   = {SLAVE_ADDR, 1'b0};   // write
            end
            st_addr16:  p.tx = c.addr[15:8];
            st_addr8:   p.tx = c.addr[7:0];
            st_addr_rd: begin
                p.kind = ph_restart_byte;
                p.tx   = {SLAVE_ADDR, 1'b1};   // read
            end
            st_data_rd: begin
                p.kind = ph_read_byte;
                p.tx   = 8'hff;
            end
            st_stop:    p.kind = ph_stop;
            default: ;
        endcase
        return p;
    endfunction

    always_comb begin
        nxt_state = state;
        case (state)
            st_idle:    if (cmd_start) nxt_state = st_sladdr;
            st_sladdr:  if (phase_done) nxt_state = cmd.bit_ctrl ? st_addr16 : st_addr8;
            st_addr16:  if (phase_done) nxt_state = st_addr8;
            st_addr8:   if (phase_done) nxt_state = cmd.rh_wl ? st_addr_rd : st_data_wr;
            st_data_wr: if (phase_done) nxt_state = st_stop;
            st_addr_rd: if (phase_done) nxt_state = st_data_rd;
            st_data_rd: if (phase_done) nxt_state = st_stop;
            st_stop:    if (phase_done) nxt_state = st_idle;
            default:    nxt_state = st_idle;
        endcase
    end

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            req      <= '0;
            xfer_end <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            state    <= nxt_state;
            req.go   <= 1'b0;
            xfer_end <= (state == st_stop) && phase_done;
            if (nxt_state != state)
                req <= phase_for(nxt_state, cmd);   // go back to 0 on idle
            if (cmd_start)
                rd_valid <= 1'b0;
            else if (state == st_data_rd && phase_done)
                rd_valid <= 1'b1;
        end
    end

    always_ff @(posedge dri_clk) begin
        if (state == st_data_rd && phase_done)
            rd_byte <= rx_byte;
    end

    assign idle   = (state == st_idle);
    assign result = '{xfer_end: xfer_end, rd_valid: rd_valid, rd_byte: rd_byte};

    a_one_phase : assert property (@(posedge dri_clk) disable iff (!rst_n)
        req.go |=> !req.go until_with phase_done)
    else $error("phase request while a phase is running");

endmodule

// ==== src/i2c_byte_engine.sv ====
`timescale 1ns/100ps

module i2c_byte_engine import i2c_bus_pkg::*, i2c_seq_pkg::*; (
    input  logic       dri_clk,
    input  logic       rst_n,
    input  logic       tick,
    input  phase_req_t req,
    input  logic       sda_sync,
    output logic       scl_drv,
    output logic       sda_drv,
    output logic       sda_oe,
    output logic       phase_done,
    output byte_t      rx_byte
);

    localparam int STEP_W = $clog2(TICKS_PER_BIT);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(TICKS_PER_BIT - 1);
    localparam logic [3:0] ACK_SEG       = 4'd9;
    localparam logic [3:0] LAST_STOP_SEG = 4'(STOP_IDLE_TICKS / TICKS_PER_BIT);

    logic              busy;
    phase_kind_t       kind;
    byte_t             shreg;
    logic [STEP_W-1:0] step;      // quarter within a bit
    logic [3:0]        seg;       // 0 framing, 1..8 bits, 9 ack
    logic [3:0]        last_seg;
    logic              rd_kind;
    logic              go_framed;

    assign rd_kind   = (kind == ph_read_byte);
    assign last_seg  = (kind == ph_stop) ? LAST_STOP_SEG : ACK_SEG;
    assign go_framed = (req.kind != ph_byte) && (req.kind != ph_read_byte);
    assign rx_byte   = shreg;

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            kind       <= ph_stop;
            shreg      <= '0;
            step       <= '0;
            seg        <= '0;
            scl_drv    <= 1'b1;
            sda_drv    <= 1'b1;
            sda_oe     <= 1'b1;
            phase_done <= 1'b0;
        end else begin
            phase_done <= 1'b0;
            if (!busy) begin
                if (req.go) begin
                    busy  <= 1'b1;
                    kind  <= req.kind;
                    shreg <= req.tx;
                    step  <= '0;
                    seg   <= go_framed ? 4'd0 : 4'd1;
                end
            end else if (tick) begin
                if (kind == ph_stop) begin
                    if (seg == 4'd0) begin
                        case (step)
                            0: begin
                                sda_oe  <= 1'b1;
                                sda_drv <= 1'b0;
                            end
                            1: scl_drv <= 1'b1;
                            3: sda_drv <= 1'b1;   // stop condition
                            default: ;
                        endcase
                    end
                end else if (seg == 4'd0) begin
                    // start and restart share one preamble
                    case (step)
                        0: begin
                            sda_oe  <= 1'b1;
                            sda_drv <= 1'b1;
                        end
                        1: scl_drv <= 1'b1;
                        2: sda_drv <= 1'b0;
                        3: scl_drv <= 1'b0;
                        default: ;
                    endcase
                end else begin
                    case (step)
                        0: begin
                            if (seg == ACK_SEG) begin
                                sda_oe  <= rd_kind;   // nack on reads
                                sda_drv <= 1'b1;
                            end else begin
                                sda_oe  <= !rd_kind;
                                sda_drv <= shreg[7];  // msb first
                            end
                        end
                        1: scl_drv <= 1'b1;
                        2: if (rd_kind && seg != ACK_SEG) shreg <= {shreg[6:0], sda_sync};
                        3: begin
                            scl_drv <= 1'b0;
                            if (!rd_kind)
                                shreg <= {shreg[6:0], 1'b0};
                        end
                        default: ;
                    endcase
                end

                if (step == LAST_STEP) begin
                    step <= '0;
                    if (seg == last_seg) begin
                        busy       <= 1'b0;
                        phase_done <= 1'b1;
                    end else begin
                        seg <= seg + 4'd1;
                    end
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    // sda may only move under a high scl for start, restart and stop
    a_sda_framing : assert property (@(posedge dri_clk) disable iff (!rst_n)
        (sda_oe && $past(sda_oe) && $changed(sda_drv) && scl_drv && $past(scl_drv))
            |-> ($past(seg) == 4'd0))
    else $error("sda moved while scl was high inside a data or ack bit");

endmodule

// ==== src/i2c_bus_out.sv ====
`timescale 1ns/100ps

module i2c_bus_out import i2c_bus_pkg::*; (
    input  logic        dri_clk,
    input  logic        rst_n,
    input  logic        scl_drv,
    input  logic        sda_drv,
    input  logic        sda_oe,
    input  i2c_result_t result,
    output logic        scl,
    output logic        sda_sync,
    output byte_t       i2c_data_r,
    output logic        i2c_done,
    inout  wire         sda
);

    logic sda_meta;

    assign sda = sda_oe ? sda_drv : 1'bz;   // push-pull or released

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            scl        <= 1'b1;
            sda_meta   <= 1'b1;
            sda_sync   <= 1'b1;
            i2c_data_r <= '0;
            i2c_done   <= 1'b0;
        end else begin
            scl      <= scl_drv;
            sda_meta <= sda;        // two flop sync
            sda_sync <= sda_meta;
            i2c_done <= result.xfer_end;
            if (result.xfer_end && result.rd_valid)
                i2c_data_r <= result.rd_byte;
        end
    end

    a_done_pulse : assert property (@(posedge dri_clk) disable iff (!rst_n)
        i2c_done |=> !i2c_done)
    else $error("i2c_done longer than one cycle");

endmodule

// ==== src/i2c_master.sv ====
`timescale 1ns/100ps

module i2c_master import i2c_bus_pkg::*, i2c_seq_pkg::*; #(
    parameter int        CLK_FREQ   = 50_000_000,
    parameter int        I2C_FREQ   = 250_000,
    parameter dev_addr_t SLAVE_ADDR = 7'b1010000
) (
    input  logic       dri_clk,
    input  logic       rst_n,
    input  logic       i2c_exec,
    input  logic       i2c_rh_wl,
    input  logic       bit_ctrl,
    input  word_addr_t i2c_addr,
    input  byte_t      i2c_data_w,
    output byte_t      i2c_data_r,
    output logic       i2c_done,
    output logic       scl,
    inout  wire        sda
);

    logic        tick;
    i2c_cmd_t    cmd;
    logic        cmd_start;
    logic        idle;
    phase_req_t  req;
    logic        phase_done;
    byte_t       rx_byte;
    i2c_result_t result;
    logic        scl_drv;
    logic        sda_drv;
    logic        sda_oe;
    logic        sda_sync;

    // ******************************
    // command side
    // ******************************
    i2c_quarter_tick #(.CLK_FREQ(CLK_FREQ), .I2C_FREQ(I2C_FREQ)) u_tick (
        .dri_clk(dri_clk), .rst_n(rst_n), .tick(tick));

    i2c_cmd_capture u_cmd (
        .dri_clk(dri_clk), .rst_n(rst_n), .i2c_exec(i2c_exec),
        .i2c_rh_wl(i2c_rh_wl), .bit_ctrl(bit_ctrl), .i2c_addr(i2c_addr),
        .i2c_data_w(i2c_data_w), .idle(idle), .cmd(cmd), .cmd_start(cmd_start));

    i2c_sequencer #(.SLAVE_ADDR(SLAVE_ADDR)) u_seq (
        .dri_clk(dri_clk), .rst_n(rst_n), .cmd(cmd), .cmd_start(cmd_start),
        .phase_done(phase_done), .rx_byte(rx_byte), .idle(idle),
        .req(req), .result(result));

    // ******************************
    // bus side
    // ******************************
    i2c_byte_engine u_engine (
        .dri_clk(dri_clk), .rst_n(rst_n), .tick(tick), .req(req),
        .sda_sync(sda_sync), .scl_drv(scl_drv), .sda_drv(sda_drv),
        .sda_oe(sda_oe), .phase_done(phase_done), .rx_byte(rx_byte));

    i2c_bus_out u_bus (
        .dri_clk(dri_clk), .rst_n(rst_n), .scl_drv(scl_drv), .sda_drv(sda_drv),
        .sda_oe(sda_oe), .result(result), .scl(scl), .sda_sync(sda_sync),
        .i2c_data_r(i2c_data_r), .i2c_done(i2c_done), .sda(sda));

endmodule

// ==== bench/i2c_eeprom_model.sv ====
`timescale 1ns/100ps

module i2c_eeprom_model import i2c_bus_pkg::*; #(
    parameter dev_addr_t SLAVE_ADDR = 7'h50,
    parameter int        DRIVE_DLY  = 500     // ns after scl falls
) (
    input  wire scl,
    inout  wire sda
);

    localparam int MODE_RX  = 0;
    localparam int MODE_TX  = 1;
    localparam int MODE_END = 2;   // nack seen, waiting for stop

    byte_t      mem [0:65535];
    byte_t      fb [0:3];          // bytes after the write device address
    byte_t      shreg;
    byte_t      tx_byte;
    word_addr_t ptr;
    logic       pull_low;
    logic       in_frame;
    logic       first_byte;
    logic       restarted;
    logic       rd_pend;
    logic       rd_done;
    int         bit_cnt;
    int         mode;
    int         nb;
    int         err_cnt;
    int         frame_cnt;
    int         last_addr_bytes;
    logic       last_is_read;
    word_addr_t last_addr;

    assign sda = pull_low ? 1'b0 : 1'bz;
    pullup (sda);

    function automatic byte_t blank_byte(input word_addr_t a);
        return a[15:8] ^ a[7:0] ^ 8'h5a;
    endfunction

    task automatic flag_error(input string msg);
        err_cnt++;
        $display("%0t ns: eeprom model saw a bad frame, %s", $time, msg);
    endtask

    task automatic take_byte();
        if (first_byte) begin
            first_byte = 1'b0;
            if (shreg != {SLAVE_ADDR, restarted})
                flag_error($sformatf("wrong device address byte %h", shreg));
            else if (restarted)
                rd_pend = 1'b1;
        end else if (restarted) begin
            flag_error("a byte was written after the repeated start");
        end else begin
            if (nb < 4)
                fb[nb] = shreg;
            nb++;
        end
    endtask

    task automatic close_frame();
        if (restarted) begin
            if (!rd_done)
                flag_error("read frame stopped before its data byte");
            last_is_read    = 1'b1;
            last_addr       = ptr;
            last_addr_bytes = nb;
        end else begin
            if (nb < 2 || nb > 3) begin
                flag_error($sformatf("write frame carried %0d bytes", nb));
            end else begin
                last_addr      = (nb == 3) ? {fb[0], fb[1]} : {8'h00, fb[0]};
                mem[last_addr] = fb[nb-1];
            end
            last_is_read    = 1'b0;
            last_addr_bytes = nb - 1;
        end
        frame_cnt++;
    endtask

    initial begin
        pull_low  = 1'b0;
        in_frame  = 1'b0;
        err_cnt   = 0;
        frame_cnt = 0;
        for (int a = 0; a < 65536; a++)
            mem[a] = blank_byte(a[15:0]);
    end

    // ******************************
    // start, restart and stop
    // ******************************
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            if (in_frame) begin
                if (restarted || first_byte || mode != MODE_RX || nb < 1 || nb > 2)
                    flag_error("repeated start in the wrong place");
                ptr       = (nb == 2) ? {fb[0], fb[1]} : {8'h00, fb[0]};
                restarted = 1'b1;
            end else begin
                nb        = 0;
                restarted = 1'b0;
                rd_done   = 1'b0;
            end
            in_frame   = 1'b1;
            first_byte = 1'b1;
            bit_cnt    = 0;
            mode       = MODE_RX;
            rd_pend    = 1'b0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1 && in_frame === 1'b1) begin
            in_frame = 1'b0;
            pull_low = 1'b0;
            close_frame();
        end
    end

    // ******************************
    // bit level
    // ******************************
    always @(posedge scl) begin
        if (in_frame === 1'b1) begin
            if (bit_cnt < 8) begin
                shreg = {shreg[6:0], sda};
                bit_cnt++;
                if (bit_cnt == 8 && mode == MODE_RX)
                    take_byte();
            end else if (bit_cnt == 8) begin
                if (mode == MODE_TX) begin
                    if (sda !== 1'b1)
                        flag_error("master acked the read byte instead of a nack");
                    rd_done = 1'b1;
                    mode    = MODE_END;
                end
                bit_cnt = 9;
            end
        end
    end

    always @(negedge scl) begin
        logic want_low;
        want_low = 1'b0;
        if (in_frame === 1'b1) begin
            pull_low = 1'b0;              // release right away
            if (bit_cnt == 9) begin
                bit_cnt = 0;
                if (rd_pend) begin
                    mode    = MODE_TX;
                    rd_pend = 1'b0;
                    tx_byte = mem[ptr];
                end
            end
            if (mode == MODE_RX && bit_cnt == 8)
                want_low = 1'b1;          // ack
            else if (mode == MODE_TX && bit_cnt < 8)
                want_low = !tx_byte[7 - bit_cnt];
            if (want_low) begin
                #(DRIVE_DLY);             // master has let go by now
                if (scl === 1'b0)
                    pull_low = 1'b1;
            end
        end
    end

endmodule

// ==== bench/tb_i2c_master.sv ====
`timescale 1ns/100ps

module tb_i2c_master import i2c_bus_pkg::*; ();

    typedef struct packed {
        logic       is_read;
        logic       bit_ctrl;
        word_addr_t addr;        // address as the eeprom sees it
        byte_t      data;
    } expect_t;

    logic        dri_clk;
    logic        rst_n;
    logic        i2c_exec;
    logic        i2c_rh_wl;
    logic        bit_ctrl;
    word_addr_t  i2c_addr;
    byte_t       i2c_data_w;
    byte_t       i2c_data_r;
    logic        i2c_done;
    logic        scl;
    wire         sda;

    logic [31:0] lcg_state;
    byte_t       shadow [0:65535];
    logic        written [0:65535];
    expect_t     exp_q [$];
    int          err_cnt;
    int          done_cnt;
    int          n_cmds;
    int          timeouts;
    logic        done_prev;

    i2c_master #(
        .CLK_FREQ(25_000_000), .I2C_FREQ(625_000), .SLAVE_ADDR(7'h50)
    ) uut (
        .dri_clk(dri_clk), .rst_n(rst_n), .i2c_exec(i2c_exec), .i2c_rh_wl(i2c_rh_wl),
        .bit_ctrl(bit_ctrl), .i2c_addr(i2c_addr), .i2c_data_w(i2c_data_w),
        .i2c_data_r(i2c_data_r), .i2c_done(i2c_done), .scl(scl), .sda(sda));

    i2c_eeprom_model #(.SLAVE_ADDR(7'h50)) model (.scl(scl), .sda(sda));

    initial begin
        dri_clk = 1'b0;
        forever #20 dri_clk = ~dri_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // content of a location nobody has written
    function automatic byte_t init_byte(input word_addr_t addr);
        return addr[15:8] ^ addr[7:0] ^ 8'h5a;
    endfunction

    function automatic byte_t expected_byte(input word_addr_t addr);
        return written[addr] ? shadow[addr] : init_byte(addr);
    endfunction

    task automatic run_cmd(input logic rd, input logic bc, input word_addr_t addr,
                           input byte_t data, input logic extra_strobe);
        expect_t e;
        int      target;
        int      waited;
        if (timeouts != 0)
            return;
        e.is_read  = rd;
        e.bit_ctrl = bc;
        e.addr     = bc ? addr : {8'h00, addr[7:0]};
        e.data     = rd ? expected_byte(e.addr) : data;
        if (!rd) begin
            shadow[e.addr]  = data;
            written[e.addr] = 1'b1;
        end
        exp_q.push_back(e);
        n_cmds++;
        target = done_cnt + 1;
        @(posedge dri_clk);
        i2c_exec   <= 1'b1;
        i2c_rh_wl  <= rd;
        bit_ctrl   <= bc;
        i2c_addr   <= addr;
        i2c_data_w <= data;
        @(posedge dri_clk);
        i2c_exec <= 1'b0;
        if (extra_strobe) begin
            repeat (300) @(posedge dri_clk);   // well inside the frame
            i2c_exec   <= 1'b1;
            i2c_rh_wl  <= !rd;
            bit_ctrl   <= !bc;
            i2c_addr   <= ~addr;
            i2c_data_w <= ~data;
            @(posedge dri_clk);
            i2c_exec <= 1'b0;
        end
        waited = 0;
        while (done_cnt < target && waited < 20000) begin
            @(negedge dri_clk);
            waited++;
        end
        if (done_cnt < target) begin
            timeouts++;
            $display("%0t ns: no i2c_done within 20000 cycles of i2c_exec", $time);
        end
    endtask

    // ******************************
    // compare process
    // ******************************
    always @(posedge dri_clk) begin
        expect_t e;
        if (rst_n) begin
            assert (!(i2c_done && done_prev))
            else begin
                err_cnt++;
                $display("%0t ns: i2c_done stayed high for more than one cycle", $time);
            end
            done_prev = i2c_done;
            if (i2c_done) begin
                done_cnt++;
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("%0t ns: i2c_done came without a pending command", $time);
                end else begin
                    e = exp_q.pop_front();
                    if (e.is_read)
                        assert (i2c_data_r == e.data)
                        else begin
                            err_cnt++;
                            $display("mismatch at %0t ns: read of %h gave %h, expected %h",
                                     $time, e.addr, i2c_data_r, e.data);
                        end
                    assert (model.frame_cnt == done_cnt && model.last_is_read == e.is_read &&
                            model.last_addr == e.addr &&
                            model.last_addr_bytes == (e.bit_ctrl ? 2 : 1))
                    else begin
                        err_cnt++;
                        $display("mismatch at %0t ns: frame %0d rd %b addr %h/%0d bytes, %s",
                                 $time, model.frame_cnt, model.last_is_read, model.last_addr,
                                 model.last_addr_bytes, "not what the command asked for");
                    end
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        int          i;
        rst_n      = 1'b0;
        i2c_exec   = 1'b0;
        i2c_rh_wl  = 1'b0;
        bit_ctrl   = 1'b0;
        i2c_addr   = '0;
        i2c_data_w = '0;
        lcg_state  = 32'h048eff2a;
        err_cnt    = 0;
        done_cnt   = 0;
        n_cmds     = 0;
        timeouts   = 0;
        done_prev  = 1'b0;
        for (i = 0; i < 65536; i++)
            written[i] = 1'b0;
        repeat (2) @(posedge dri_clk);
        rst_n <= 1'b1;
        @(negedge dri_clk);
        assert (scl === 1'b1 && sda === 1'b1 && i2c_done === 1'b0 && i2c_data_r === 8'h00)
        else begin
            err_cnt++;
            $display("mismatch at %0t ns: after reset scl %b sda %b done %b data_r %h",
                     $time, scl, sda, i2c_done, i2c_data_r);
        end

        run_cmd(1'b0, 1'b0, 16'h003c, 8'ha5, 1'b0);   // 8-bit write and read back
        run_cmd(1'b1, 1'b0, 16'h003c, 8'h00, 1'b0);
        run_cmd(1'b0, 1'b1, 16'h12c7, 8'h69, 1'b0);   // 16-bit pair
        run_cmd(1'b1, 1'b1, 16'h12c7, 8'h00, 1'b0);
        run_cmd(1'b1, 1'b1, 16'h13c7, 8'h00, 1'b0);   // high byte neighbour
        run_cmd(1'b1, 1'b0, 16'h0081, 8'h00, 1'b0);   // never written
        run_cmd(1'b1, 1'b1, 16'hbe04, 8'h00, 1'b0);

        for (i = 0; i < 40; i++) begin
            lcg_state = lcg_next(lcg_state);
            r = lcg_state;
            run_cmd(r[0], r[1], {6'h00, r[9:8], 5'h00, r[4:2]}, r[31:24], (i % 8) == 3);
        end

        repeat (3000) @(posedge dri_clk);   // room for a stray frame or done
        assert (exp_q.size() == 0 && done_cnt == n_cmds && model.frame_cnt == n_cmds)
        else begin
            err_cnt++;
            $display("%0t ns: %0d commands gave %0d done pulses and %0d frames",
                     $time, n_cmds, done_cnt, model.frame_cnt);
        end

        $display("errors: checks %0d, frames %0d, timeouts %0d",
                 err_cnt, model.err_cnt, timeouts);
        if (err_cnt == 0 && model.err_cnt == 0 && timeouts == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== i2c_master.f ====
src/i2c_bus_pkg.sv
src/i2c_seq_pkg.sv
src/i2c_quarter_tick.sv
src/i2c_cmd_capture.sv
src/i2c_sequencer.sv
src/i2c_byte_engine.sv
src/i2c_bus_out.sv
src/i2c_master.sv
bench/i2c_eeprom_model.sv
bench/tb_i2c_master.sv
